//--- logic/color_pkg.sv
`default_nettype none

package color_pkg;

    // ******************************************************************
    // vector types
    // ******************************************************************
    typedef logic [7:0]         chan_t;         // one colour or luma/chroma byte
    typedef logic [2:0]         level_t;        // offset level, 4 is neutral
    typedef logic [3:0]         apb_addr_t;     // apb byte address
    typedef logic signed [19:0] acc_t;          // signed working width for the math

    // pixel bundle, c0/c1/c2 are r/g/b or y/cb/cr depending on the stage
    typedef struct packed {
        logic  vs;                              // vertical sync
        logic  hs;                              // horizontal sync
        logic  de;                              // data enable
        chan_t c0;                              // red or y
        chan_t c1;                              // green or cb
        chan_t c2;                              // blue or cr
    } pix_t;

    // per-channel levels, packed in register bit order
    typedef struct packed {
        level_t cr_lvl;                         // bits 8:6
        level_t cb_lvl;                         // bits 5:3
        level_t y_lvl;                          // bits 2:0
    } levels_t;

    // ******************************************************************
    // register map
    // ******************************************************************
    localparam apb_addr_t ADDR_CTRL   = 4'h0;   // bit 0 process_en
    localparam apb_addr_t ADDR_LEVELS = 4'h4;   // y, cb, cr levels
    localparam level_t    LEVEL_ZERO  = 3'd4;   // no offset

    // saturate a signed result into one byte
    function automatic chan_t clamp8(input acc_t v);
        chan_t res;
        if (v < 0) begin
            res = 8'h00;                        // underflow
        end else if (v > 20'sd255) begin
            res = 8'hff;                        // overflow
        end else begin
            res = v[7:0];
        end
        return res;
    endfunction

endpackage

`default_nettype wire

//--- logic/color_regs.sv
`timescale 1ns/100ps
`default_nettype none

module color_regs (
    input  wire logic                hdmi_rx_pix_clk,
    input  wire logic                key_rst_n,
    input  wire logic                psel,
    input  wire logic                penable,
    input  wire logic                pwrite,
    input  wire color_pkg::apb_addr_t paddr,
    input  wire logic [31:0]         pwdata,
    output logic [31:0]              prdata,
    output logic                     pready,
    output logic                     pslverr,
    output logic                     process_en,
    output color_pkg::levels_t       levels
);
    import color_pkg::*;

    logic access;                               // access phase of a transfer
    logic addr_ok;                              // address hits the map
    logic wr_en;                                // valid write this cycle

    // ******************************************************************
    // decode
    // ******************************************************************
    assign access  = psel & penable;
    assign addr_ok = (paddr == ADDR_CTRL) || (paddr == ADDR_LEVELS);
    assign wr_en   = access & pwrite & addr_ok;

    assign pready  = 1'b1;                      // zero wait states
    assign pslverr = access & ~addr_ok;         // unmapped address

    // ******************************************************************
    // registers
    // ******************************************************************
    always_ff @(posedge hdmi_rx_pix_clk) begin
        if (!key_rst_n) begin
            process_en <= 1'b1;                 // processing on by default
            levels     <= '{LEVEL_ZERO, LEVEL_ZERO, LEVEL_ZERO};
        end else if (wr_en) begin
            case (paddr)
                ADDR_CTRL:   process_en <= pwdata[0];
                ADDR_LEVELS: levels     <= levels_t'(pwdata[8:0]); // cr, cb, y
                default: ;
            endcase
        end
    end

    // read mux, unused bits and bad addresses give zero
    always_comb begin
        prdata = 32'd0;
        case (paddr)
            ADDR_CTRL:   prdata[0]   = process_en;
            ADDR_LEVELS: prdata[8:0] = levels;
            default: ;
        endcase
    end

endmodule

`default_nettype wire

//--- logic/rgb_to_ycbcr.sv
`timescale 1ns/100ps
`default_nettype none

module rgb_to_ycbcr (
    input  wire logic            hdmi_rx_pix_clk,
    input  wire logic            key_rst_n,
    input  wire color_pkg::pix_t pix_in,
    output color_pkg::pix_t      ycc,
    output color_pkg::pix_t      raw
);
    import color_pkg::*;

    pix_t in_r;                                 // stage 1, registered input
    pix_t s1;                                   // stage 2, rgb and sync copy
    acc_t y_acc;                                // weighted sums, stage 2
    acc_t cb_acc;
    acc_t cr_acc;
    acc_t r_s;                                  // zero-extended rgb
    acc_t g_s;
    acc_t b_s;

    assign r_s = {12'd0, in_r.c0};
    assign g_s = {12'd0, in_r.c1};
    assign b_s = {12'd0, in_r.c2};

    // ******************************************************************
    // stage 1, input register
    // ******************************************************************
    always_ff @(posedge hdmi_rx_pix_clk) begin
        if (!key_rst_n) begin
            in_r <= '0;
        end else begin
            in_r <= pix_in;                     // sample hdmi rx pins
        end
    end

    // ******************************************************************
    // stage 2, weighted sums
    // ******************************************************************
    always_ff @(posedge hdmi_rx_pix_clk) begin
        if (!key_rst_n) begin
            s1     <= '0;
            y_acc  <= '0;
            cb_acc <= '0;
            cr_acc <= '0;
        end else begin
            s1     <= in_r;                                        // sync and rgb ride along
            y_acc  <= 20'sd77 * r_s + 20'sd150 * g_s + 20'sd29 * b_s;
            cb_acc <= 20'sd128 * b_s - 20'sd43 * r_s - 20'sd85 * g_s;
            cr_acc <= 20'sd128 * r_s - 20'sd107 * g_s - 20'sd21 * b_s;
        end
    end

    // ******************************************************************
    // stage 3, shift, offset, clamp
    // ******************************************************************
    always_ff @(posedge hdmi_rx_pix_clk) begin
        if (!key_rst_n) begin
            ycc <= '0;
            raw <= '0;
        end else begin
            ycc.vs <= s1.vs;
            ycc.hs <= s1.hs;
            ycc.de <= s1.de;
            ycc.c0 <= clamp8(y_acc >>> 8);                  // y, no offset
            ycc.c1 <= clamp8((cb_acc >>> 8) + 20'sd128);    // cb centred at 128
            ycc.c2 <= clamp8((cr_acc >>> 8) + 20'sd128);    // cr centred at 128
            raw    <= s1;                                   // untouched rgb for bypass
        end
    end

endmodule

`default_nettype wire

//--- logic/ycbcr_adjust.sv
`timescale 1ns/100ps
`default_nettype none

module ycbcr_adjust #(
    parameter int LEVEL_STEP = 8                // offset per level step
) (
    input  wire logic               hdmi_rx_pix_clk,
    input  wire logic               key_rst_n,
    input  wire color_pkg::pix_t    ycc,
    input  wire color_pkg::pix_t    raw,
    input  wire logic               process_en,
    input  wire color_pkg::levels_t levels,
    output color_pkg::pix_t         adj,
    output logic                    bypass
);
    import color_pkg::*;

    localparam acc_t STEP = acc_t'(LEVEL_STEP);

    pix_t adj_next;                             // adjusted ycbcr, pre-register

    // add (level - 4) * step to one component and saturate
    function automatic chan_t add_lvl(input chan_t c, input level_t lvl);
        acc_t off;
        off = ($signed({17'd0, lvl}) - 20'sd4) * STEP;
        return clamp8($signed({12'd0, c}) + off);
    endfunction

    always_comb begin
        adj_next.vs = ycc.vs;
        adj_next.hs = ycc.hs;
        adj_next.de = ycc.de;
        adj_next.c0 = add_lvl(ycc.c0, levels.y_lvl);   // y
        adj_next.c1 = add_lvl(ycc.c1, levels.cb_lvl);  // cb
        adj_next.c2 = add_lvl(ycc.c2, levels.cr_lvl);  // cr
    end

    // ******************************************************************
    // single registered stage
    // ******************************************************************
    always_ff @(posedge hdmi_rx_pix_clk) begin
        if (!key_rst_n) begin
            adj    <= '0;
            bypass <= 1'b0;
        end else begin
            adj    <= process_en ? adj_next : raw;   // raw rgb when disabled
            bypass <= ~process_en;                   // flag travels with pixel
        end
    end

endmodule

`default_nettype wire

//--- logic/ycbcr_to_rgb.sv
`timescale 1ns/100ps
`default_nettype none

module ycbcr_to_rgb (
    input  wire logic            hdmi_rx_pix_clk,
    input  wire logic            key_rst_n,
    input  wire color_pkg::pix_t adj,
    input  wire logic            bypass,
    output color_pkg::pix_t      pix_out
);
    import color_pkg::*;

    acc_t cb_d;                                 // cb - 128
    acc_t cr_d;                                 // cr - 128
    pix_t s1;                                   // stage 1, y and sync
    logic s1_bypass;
    acc_t r_prod;                               // 359 * cr
    acc_t g_cb;                                 // 88 * cb
    acc_t g_cr;                                 // 183 * cr
    acc_t b_prod;                               // 454 * cb
    acc_t y_s;                                  // stage 1 luma, extended
    pix_t conv;                                 // converted rgb, pre-register
    pix_t s2;                                   // stage 2 result

    assign cb_d = $signed({12'd0, adj.c1}) - 20'sd128;
    assign cr_d = $signed({12'd0, adj.c2}) - 20'sd128;

    // ******************************************************************
    // stage 1, chroma products
    // ******************************************************************
    always_ff @(posedge hdmi_rx_pix_clk) begin
        if (!key_rst_n) begin
            s1        <= '0;
            s1_bypass <= 1'b0;
            r_prod    <= '0;
            g_cb      <= '0;
            g_cr      <= '0;
            b_prod    <= '0;
        end else begin
            s1        <= adj;                   // sync, y, or raw rgb
            s1_bypass <= bypass;
            r_prod    <= 20'sd359 * cr_d;
            g_cb      <= 20'sd88 * cb_d;
            g_cr      <= 20'sd183 * cr_d;
            b_prod    <= 20'sd454 * cb_d;
        end
    end

    // ******************************************************************
    // stage 2, sum, shift, clamp
    // ******************************************************************
    assign y_s = $signed({12'd0, s1.c0});

    always_comb begin
        conv.vs = s1.vs;
        conv.hs = s1.hs;
        conv.de = s1.de;
        conv.c0 = clamp8(y_s + (r_prod >>> 8));            // red
        conv.c1 = clamp8(y_s - ((g_cb + g_cr) >>> 8));     // green
        conv.c2 = clamp8(y_s + (b_prod >>> 8));            // blue
    end

    always_ff @(posedge hdmi_rx_pix_clk) begin
        if (!key_rst_n) begin
            s2 <= '0;
        end else begin
            s2 <= s1_bypass ? s1 : conv;        // already rgb when bypassed
        end
    end

    // ******************************************************************
    // stage 3, output register
    // ******************************************************************
    always_ff @(posedge hdmi_rx_pix_clk) begin
        if (!key_rst_n) begin
            pix_out <= '0;
        end else begin
            pix_out <= s2;
        end
    end

endmodule

`default_nettype wire

//--- logic/video_color_top.sv
`timescale 1ns/100ps
`default_nettype none

module video_color_top #(
    parameter int LEVEL_STEP = 8                // ycbcr offset per level
) (
    input  wire logic                 hdmi_rx_pix_clk,
    input  wire logic                 key_rst_n,
    // apb
    input  wire logic                 psel,
    input  wire logic                 penable,
    input  wire logic                 pwrite,
    input  wire color_pkg::apb_addr_t paddr,
    input  wire logic [31:0]          pwdata,
    output logic [31:0]               prdata,
    output logic                      pready,
    output logic                      pslverr,
    // hdmi receive
    input  wire logic                 hdmi_rx_vs,
    input  wire logic                 hdmi_rx_hs,
    input  wire logic                 hdmi_rx_de,
    input  wire logic [23:0]          hdmi_rx_data,
    // hdmi transmit
    output logic                      hdmi_tx_vs,
    output logic                      hdmi_tx_hs,
    output logic                      hdmi_tx_de,
    output logic [23:0]               hdmi_tx_data
);
    import color_pkg::*;

    pix_t    pix_in;                            // rx pins as a bundle
    pix_t    ycc;                               // decode stage out
    pix_t    raw;                               // rgb copy for bypass
    pix_t    adj;                               // execute stage out
    pix_t    pix_out;                           // result stage out
    logic    bypass;
    logic    process_en;
    levels_t levels;

    // red in the upper byte, blue in the lower
    assign pix_in = '{hdmi_rx_vs, hdmi_rx_hs, hdmi_rx_de,
                      hdmi_rx_data[23:16], hdmi_rx_data[15:8], hdmi_rx_data[7:0]};

    assign hdmi_tx_vs   = pix_out.vs;
    assign hdmi_tx_hs   = pix_out.hs;
    assign hdmi_tx_de   = pix_out.de;
    assign hdmi_tx_data = {pix_out.c0, pix_out.c1, pix_out.c2};

    // ******************************************************************
    // control registers
    // ******************************************************************
    color_regs u_color_regs (
        .hdmi_rx_pix_clk (hdmi_rx_pix_clk),
        .key_rst_n       (key_rst_n),
        .psel            (psel),
        .penable         (penable),
        .pwrite          (pwrite),
        .paddr           (paddr),
        .pwdata          (pwdata),
        .prdata          (prdata),
        .pready          (pready),
        .pslverr         (pslverr),
        .process_en      (process_en),
        .levels          (levels)
    );

    // ******************************************************************
    // pixel pipeline, 3 + 1 + 3 cycles
    // ******************************************************************
    rgb_to_ycbcr u_rgb_to_ycbcr (
        .hdmi_rx_pix_clk (hdmi_rx_pix_clk),
        .key_rst_n       (key_rst_n),
        .pix_in          (pix_in),
        .ycc             (ycc),
        .raw             (raw)
    );

    ycbcr_adjust #(
        .LEVEL_STEP      (LEVEL_STEP)
    ) u_ycbcr_adjust (
        .hdmi_rx_pix_clk (hdmi_rx_pix_clk),
        .key_rst_n       (key_rst_n),
        .ycc             (ycc),
        .raw             (raw),
        .process_en      (process_en),
        .levels          (levels),
        .adj             (adj),
        .bypass          (bypass)
    );

    ycbcr_to_rgb u_ycbcr_to_rgb (
        .hdmi_rx_pix_clk (hdmi_rx_pix_clk),
        .key_rst_n       (key_rst_n),
        .adj             (adj),
        .bypass          (bypass),
        .pix_out         (pix_out)
    );

endmodule

`default_nettype wire

//--- bench/video_color_properties.sv
`timescale 1ns/100ps
`default_nettype none

module video_color_properties (
    input wire logic hdmi_rx_pix_clk,
    input wire logic key_rst_n,
    input wire logic psel,
    input wire logic penable,
    input wire logic pready,
    input wire logic pslverr,
    input wire logic de
);
    logic [3:0] since_rst;                      // cycles out of reset, saturates

    always_ff @(posedge hdmi_rx_pix_clk) begin
        if (!key_rst_n) begin
            since_rst <= 4'd0;
        end else if (since_rst != 4'hf) begin
            since_rst <= since_rst + 4'd1;
        end
    end

    // ******************************************************************
    // apb and pixel timing
    // ******************************************************************
    a_pready_high: assert property (@(posedge hdmi_rx_pix_clk) disable iff (!key_rst_n)
        pready)
        else $error("pready went low");

    a_err_in_access: assert property (@(posedge hdmi_rx_pix_clk) disable iff (!key_rst_n)
        pslverr |-> (psel && penable))
        else $error("pslverr outside an access phase");

    // pipeline still holds cleared stages
    a_de_after_reset: assert property (@(posedge hdmi_rx_pix_clk) disable iff (!key_rst_n)
        (since_rst < 4'd7) |-> !de)
        else $error("pixel out de high within 7 cycles of reset");

endmodule

bind color_regs video_color_properties u_regs_props (
    .hdmi_rx_pix_clk (hdmi_rx_pix_clk),
    .key_rst_n       (key_rst_n),
    .psel            (psel),
    .penable         (penable),
    .pready          (pready),
    .pslverr         (pslverr),
    .de              (1'b0)
);

bind ycbcr_to_rgb video_color_properties u_pipe_props (
    .hdmi_rx_pix_clk (hdmi_rx_pix_clk),
    .key_rst_n       (key_rst_n),
    .psel            (1'b0),
    .penable         (1'b0),
    .pready          (1'b1),
    .pslverr         (1'b0),
    .de              (pix_out.de)
);

`default_nettype wire

//--- bench/video_color_tb.sv
`timescale 1ns/100ps
`default_nettype none

module video_color_tb;
    import color_pkg::*;

    localparam int STEP       = 8;                      // dut level step
    localparam int N_PIX      = 2000;                   // active pixels per run
    localparam int N_SETTINGS = 4;                      // level settings in test 5
    localparam int PIX_TOTAL  = N_PIX * (2 + N_SETTINGS);
    localparam int WATCHDOG   = 2 * PIX_TOTAL + 4000;   // blanking below 1x active

    logic        hdmi_rx_pix_clk;
    logic        key_rst_n;
    logic        psel;
    logic        penable;
    logic        pwrite;
    apb_addr_t   paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
    logic        hdmi_rx_vs;
    logic        hdmi_rx_hs;
    logic        hdmi_rx_de;
    logic [23:0] hdmi_rx_data;
    logic        hdmi_tx_vs;
    logic        hdmi_tx_hs;
    logic        hdmi_tx_de;
    logic [23:0] hdmi_tx_data;

    logic [26:0] exp_q[$];                              // {vs, hs, de, rgb} seven deep
    logic        m_en;                                  // model process_en
    level_t      m_lvl[3];                              // model y, cb, cr levels
    int          errors;
    int          checks;
    int          test_err;                              // errors before current test

    video_color_top #(
        .LEVEL_STEP      (STEP)
    ) u_video_color_top (
        .hdmi_rx_pix_clk (hdmi_rx_pix_clk),
        .key_rst_n       (key_rst_n),
        .psel            (psel),
        .penable         (penable),
        .pwrite          (pwrite),
        .paddr           (paddr),
        .pwdata          (pwdata),
        .prdata          (prdata),
        .pready          (pready),
        .pslverr         (pslverr),
        .hdmi_rx_vs      (hdmi_rx_vs),
        .hdmi_rx_hs      (hdmi_rx_hs),
        .hdmi_rx_de      (hdmi_rx_de),
        .hdmi_rx_data    (hdmi_rx_data),
        .hdmi_tx_vs      (hdmi_tx_vs),
        .hdmi_tx_hs      (hdmi_tx_hs),
        .hdmi_tx_de      (hdmi_tx_de),
        .hdmi_tx_data    (hdmi_tx_data)
    );

    initial hdmi_rx_pix_clk = 1'b0;
    always #20 hdmi_rx_pix_clk = ~hdmi_rx_pix_clk;      // 40 ns period

    // ******************************************************************
    // reference model
    // ******************************************************************
    function automatic int clip(input int v);
        if (v < 0) return 0;
        if (v > 255) return 255;
        return v;
    endfunction

    function automatic logic [23:0] expect_rgb(input logic [23:0] rgb);
        int r;
        int g;
        int b;
        int y;
        int cb;
        int cr;
        if (!m_en) return rgb;                          // bypass
        r  = int'(rgb[23:16]);
        g  = int'(rgb[15:8]);
        b  = int'(rgb[7:0]);
        y  = clip((77 * r + 150 * g + 29 * b) >>> 8);
        cb = clip(((128 * b - 43 * r - 85 * g) >>> 8) + 128);
        cr = clip(((128 * r - 107 * g - 21 * b) >>> 8) + 128);
        y  = clip(y + (int'(m_lvl[0]) - 4) * STEP);     // user offsets
        cb = clip(cb + (int'(m_lvl[1]) - 4) * STEP);
        cr = clip(cr + (int'(m_lvl[2]) - 4) * STEP);
        r  = clip(y + ((359 * (cr - 128)) >>> 8));
        g  = clip(y - ((88 * (cb - 128) + 183 * (cr - 128)) >>> 8));
        b  = clip(y + ((454 * (cb - 128)) >>> 8));
        return {r[7:0], g[7:0], b[7:0]};
    endfunction

    function automatic logic [31:0] exp_ctrl();
        return {31'd0, m_en};
    endfunction

    function automatic logic [31:0] exp_levels();
        return {23'd0, m_lvl[2], m_lvl[1], m_lvl[0]};
    endfunction

    // ******************************************************************
    // per-cycle compare and drive
    // ******************************************************************
    task automatic check_out();
        logic [26:0] exp;
        exp = exp_q.pop_front();                        // pixel from 7 cycles back
        checks++;
        if (hdmi_tx_vs !== exp[26]) begin
            $display("mismatch at %0t: hdmi_tx_vs got %b expected %b",
                     $time, hdmi_tx_vs, exp[26]);
            errors++;
        end
        if (hdmi_tx_hs !== exp[25]) begin
            $display("mismatch at %0t: hdmi_tx_hs got %b expected %b",
                     $time, hdmi_tx_hs, exp[25]);
            errors++;
        end
        if (hdmi_tx_de !== exp[24]) begin
            $display("mismatch at %0t: hdmi_tx_de got %b expected %b",
                     $time, hdmi_tx_de, exp[24]);
            errors++;
        end
        if (exp[24] && hdmi_tx_data !== exp[23:0]) begin   // data only when active
            $display("mismatch at %0t: hdmi_tx_data got %h expected %h",
                     $time, hdmi_tx_data, exp[23:0]);
            errors++;
        end
    endtask

    task automatic send_pix(input logic vs, input logic hs, input logic de,
                            input logic [23:0] rgb);
        hdmi_rx_vs   = vs;
        hdmi_rx_hs   = hs;
        hdmi_rx_de   = de;
        hdmi_rx_data = rgb;
        exp_q.push_back({vs, hs, de, expect_rgb(rgb)});
    endtask

    task automatic tick(input logic vs, input logic hs, input logic de,
                        input logic [23:0] rgb);
        @(negedge hdmi_rx_pix_clk);
        check_out();
        send_pix(vs, hs, de, rgb);
    endtask

    task automatic vblank(input int n);
        repeat (n) tick(1'b1, 1'b0, 1'b0, 24'($urandom));
    endtask

    task automatic run_pixels(input int n);
        int   left;
        int   len;
        int   line;
        logic vs_on;
        left = n;
        line = 0;
        while (left > 0) begin
            len = 16 + int'($urandom % 48);             // short random lines
            if (len > left) len = left;
            repeat (len) tick(1'b0, 1'b0, 1'b1, 24'($urandom));
            left -= len;
            line++;
            vs_on = (line % 8) == 0;                    // frame every 8 lines
            repeat (2) tick(1'b0, 1'b0, 1'b0, 24'($urandom));
            repeat (2 + $urandom % 3) tick(vs_on, 1'b1, 1'b0, 24'($urandom));
            repeat (2) tick(1'b0, 1'b0, 1'b0, 24'($urandom));
        end
    endtask

    // ******************************************************************
    // apb
    // ******************************************************************
    task automatic apb_xfer(input logic wr, input apb_addr_t addr, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic err);
        tick(1'b0, 1'b0, 1'b0, 24'($urandom));
        psel    = 1'b1;                                 // setup
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = wdata;
        tick(1'b0, 1'b0, 1'b0, 24'($urandom));
        penable = 1'b1;                                 // access
        tick(1'b0, 1'b0, 1'b0, 24'($urandom));
        rdata   = prdata;                               // still in access
        err     = pslverr;
        checks++;
        if (pready !== 1'b1) begin
            $display("mismatch at %0t: pready got %b expected 1", $time, pready);
            errors++;
        end
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic reg_write(input apb_addr_t addr, input logic [31:0] wdata);
        logic [31:0] rd;
        logic        err;
        apb_xfer(1'b1, addr, wdata, rd, err);
        if (addr == ADDR_CTRL) begin
            m_en = wdata[0];
        end else if (addr == ADDR_LEVELS) begin
            m_lvl[0] = wdata[2:0];
            m_lvl[1] = wdata[5:3];
            m_lvl[2] = wdata[8:6];
        end
        if (err !== 1'b0) begin
            $display("mismatch at %0t: pslverr got %b expected 0 on write to %h",
                     $time, err, addr);
            errors++;
        end
    endtask

    task automatic reg_check(input apb_addr_t addr, input logic [31:0] exp_data,
                             input logic exp_err);
        logic [31:0] rd;
        logic        err;
        apb_xfer(1'b0, addr, 32'd0, rd, err);
        checks++;
        if (rd !== exp_data) begin
            $display("mismatch at %0t: prdata got %h expected %h", $time, rd, exp_data);
            errors++;
        end
        if (err !== exp_err) begin
            $display("mismatch at %0t: pslverr got %b expected %b", $time, err, exp_err);
            errors++;
        end
    endtask

    task automatic set_levels(input level_t y, input level_t cb, input level_t cr);
        vblank(8);                                      // pipeline empty of active pixels
        reg_write(ADDR_LEVELS, {23'd0, cr, cb, y});
        vblank(4);
    endtask

    task automatic end_test(input string name);
        $display("test %s done, %0d errors", name, errors - test_err);
        test_err = errors;
    endtask

    // ******************************************************************
    // test sequence
    // ******************************************************************
    initial begin
        logic [31:0] wd;
        logic [31:0] rd;
        logic        err;
        void'($urandom(32'hc55));
        key_rst_n    = 1'b0;
        psel         = 1'b0;
        penable      = 1'b0;
        pwrite       = 1'b0;
        paddr        = '0;
        pwdata       = '0;
        hdmi_rx_vs   = 1'b1;                            // live pixel held through reset
        hdmi_rx_hs   = 1'b1;
        hdmi_rx_de   = 1'b1;
        hdmi_rx_data = 24'($urandom);
        m_en         = 1'b1;
        m_lvl        = '{LEVEL_ZERO, LEVEL_ZERO, LEVEL_ZERO};
        errors       = 0;
        checks       = 0;
        test_err     = 0;
        repeat (6) exp_q.push_back(27'd0);              // cleared stages ahead of first pixel
        repeat (4) @(negedge hdmi_rx_pix_clk);
        key_rst_n = 1'b1;

        // test 1 reset state
        checks++;
        if ({hdmi_tx_vs, hdmi_tx_hs, hdmi_tx_de} !== 3'b000) begin
            $display("mismatch at %0t: hdmi_tx vs/hs/de got %b expected 000",
                     $time, {hdmi_tx_vs, hdmi_tx_hs, hdmi_tx_de});
            errors++;
        end
        if (hdmi_tx_data !== 24'd0) begin
            $display("mismatch at %0t: hdmi_tx_data got %h expected 000000",
                     $time, hdmi_tx_data);
            errors++;
        end
        send_pix(1'b0, 1'b0, 1'b0, 24'd0);
        reg_check(ADDR_CTRL, 32'd1, 1'b0);
        reg_check(ADDR_LEVELS, 32'h124, 1'b0);          // three levels of 4
        end_test("reset");

        // test 2 register access
        repeat (8) begin
            wd = $urandom;
            reg_write(ADDR_LEVELS, wd);
            reg_check(ADDR_LEVELS, {23'd0, wd[8:0]}, 1'b0);
            wd = $urandom;
            reg_write(ADDR_CTRL, wd);
            reg_check(ADDR_CTRL, {31'd0, wd[0]}, 1'b0);
        end
        apb_xfer(1'b1, 4'h8, $urandom, rd, err);
        if (err !== 1'b1) begin
            $display("mismatch at %0t: pslverr got %b expected 1 on write to 8", $time, err);
            errors++;
        end
        reg_check(4'h8, 32'd0, 1'b1);
        reg_check(ADDR_CTRL, exp_ctrl(), 1'b0);         // bad write changed nothing
        reg_check(ADDR_LEVELS, exp_levels(), 1'b0);
        reg_write(ADDR_CTRL, 32'd1);
        reg_write(ADDR_LEVELS, 32'h124);
        end_test("apb");

        // test 3 bypass
        vblank(8);
        reg_write(ADDR_CTRL, 32'd0);
        vblank(4);
        run_pixels(N_PIX);
        vblank(8);
        reg_write(ADDR_CTRL, 32'd1);
        vblank(4);
        end_test("bypass");

        // test 4 zero offset round trip
        run_pixels(N_PIX);
        end_test("zero offset");

        // test 5 random levels where the first two hit the clamps
        for (int i = 0; i < N_SETTINGS; i++) begin
            if (i == 0) begin
                set_levels(3'd0, 3'd0, 3'd0);
            end else if (i == 1) begin
                set_levels(3'd7, 3'd7, 3'd7);
            end else begin
                set_levels(3'($urandom), 3'($urandom), 3'($urandom));
            end
            run_pixels(N_PIX);
        end
        end_test("random levels");

        vblank(8);                                      // drain the pipeline
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    // watchdog
    initial begin
        #(WATCHDOG * 40);
        $display("timeout after %0d cycles, test sequence did not complete", WATCHDOG);
        $display("Finished with errors");
        $finish;
    end

endmodule

`default_nettype wire

//--- video_color.f
logic/color_pkg.sv
logic/color_regs.sv
logic/rgb_to_ycbcr.sv
logic/ycbcr_adjust.sv
logic/ycbcr_to_rgb.sv
logic/video_color_top.sv
bench/video_color_properties.sv
bench/video_color_tb.sv

//--- Makefile
.PHONY: sim clean

LOG = sim.log

sim:
	verilator --binary --timing --assert --top-module video_color_tb -f video_color.f
	./obj_dir/Vvideo_color_tb > $(LOG) 2>&1 || echo "Finished with errors" >> $(LOG)
	cat $(LOG)
	! grep -q "Finished with errors" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
